// ==== accumulator/fixed_point_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixed_point_accumulator (
    aclk,
    aclken,
    arst_n,

    b,
    bypass,
    q
);

    input  logic           aclk;
    input  logic           aclken;
    input  logic           arst_n;

    input  dsp_pkg::word_t b;
    input  logic           bypass;
    output dsp_pkg::word_t q;

    dsp_pkg::word_t b_q;
    logic           bypass_q;
    dsp_pkg::word_t sum_q;

    // stage 1 registers the addend and its restart flag
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            b_q      <= '0;
            bypass_q <= 1'b0;
        end else if (aclken) begin
            b_q      <= b;
            bypass_q <= bypass;
        end
    end

    // stage 2 holds the running sum
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            sum_q <= '0;
        end else if (aclken) begin
            if (bypass_q) begin
                sum_q <= b_q;                  // restart with this addend
            end else begin
                sum_q <= sum_q + b_q;          // wraps modulo 2^16
            end
        end
    end

    assign q = sum_q;

endmodule

`default_nettype wire

// ==== accumulator/fixed_point_accumulator_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixed_point_accumulator_wrapper (
    aclk,
    aclken,
    arst_n,

    data_in,
    ctrl_in,

    data_out,
    ctrl_out
);

    input  logic                  aclk;
    input  logic                  aclken;
    input  logic                  arst_n;

    input  dsp_pkg::word_t        data_in;
    input  dsp_pkg::stream_ctrl_t ctrl_in;

    output dsp_pkg::word_t        data_out;
    output dsp_pkg::stream_ctrl_t ctrl_out;

    dsp_pkg::word_t masked_data;
    logic           first_bypass;

    // non-beats add zero to the sum
    assign masked_data = data_in & {dsp_pkg::WORD_WIDTH{ctrl_in.valid}};

    // remembers whether the previous beat closed a vector
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            first_bypass <= 1'b0;              // sum is already zero after reset
        end else if (aclken && ctrl_in.valid) begin
            first_bypass <= ctrl_in.last;
        end
    end

    fixed_point_accumulator accumulator (
        .aclk   (aclk        ),
        .aclken (aclken      ),
        .arst_n (arst_n      ),
        .b      (masked_data ),
        .bypass (first_bypass),        // gaps reload zero until the next beat
        .q      (data_out    )
    );

    n_delay_stream #(
        .N (dsp_pkg::ACCUMULATOR_DELAY)
    )
    delay_others
    (
        .aclk     (aclk    ),
        .aclken   (aclken  ),
        .arst_n   (arst_n  ),
        .ctrl_in  (ctrl_in ),
        .ctrl_out (ctrl_out)
    );

endmodule

`default_nettype wire

// ==== common/dsp_pkg.sv ====
`default_nettype none

package dsp_pkg;

    // signed Q8.8 stream words
    localparam int WORD_WIDTH    = 16;
    localparam int FRAC_BITS     = 8;              // fraction bits of Q8.8
    localparam int PRODUCT_WIDTH = 2*WORD_WIDTH;   // full width of a signed product

    // sideband carried next to the data
    localparam int TUSER_WIDTH = 8;

    // core latencies, counted in enabled cycles
    localparam int MULTIPLIER_DELAY  = 3;
    localparam int ACCUMULATOR_DELAY = 2;

    typedef logic signed [WORD_WIDTH-1 : 0] word_t;

    // valid, last and user move together through every stage
    typedef struct packed {
        logic                     valid;
        logic                     last;        // closes one vector
        logic [TUSER_WIDTH-1 : 0] user;
    } stream_ctrl_t;

endpackage

`default_nettype wire

// ==== multiplier/fixed_point_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixed_point_multiplier (
    aclk,
    aclken,

    a,
    b,
    p
);

    input  logic           aclk;
    input  logic           aclken;

    input  dsp_pkg::word_t a;
    input  dsp_pkg::word_t b;
    output dsp_pkg::word_t p;

    dsp_pkg::word_t                             a_q;
    dsp_pkg::word_t                             b_q;
    logic signed [dsp_pkg::PRODUCT_WIDTH-1 : 0] prod_q;
    logic signed [dsp_pkg::PRODUCT_WIDTH-1 : 0] prod_shifted;

    // realign the Q16.16 product to Q8.8, dropping the low fraction bits
    assign prod_shifted = prod_q >>> dsp_pkg::FRAC_BITS;

    always_ff @(posedge aclk) begin
        if (aclken) begin
            a_q    <= a;                                   // stage 1
            b_q    <= b;
            prod_q <= a_q * b_q;                           // stage 2, full signed product
            p      <= prod_shifted[dsp_pkg::WORD_WIDTH-1 : 0];  // stage 3, wraps on overflow
        end
    end

endmodule

`default_nettype wire

// ==== multiplier/fixed_point_multiplier_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixed_point_multiplier_wrapper (
    aclk,
    aclken,
    arst_n,

    data_in_1,
    ctrl_in_1,

    data_in_2,
    valid_in_2,

    data_out,
    ctrl_out
);

    input  logic                  aclk;
    input  logic                  aclken;
    input  logic                  arst_n;

    input  dsp_pkg::word_t        data_in_1;
    input  dsp_pkg::stream_ctrl_t ctrl_in_1;

    input  dsp_pkg::word_t        data_in_2;
    input  logic                  valid_in_2;

    output dsp_pkg::word_t        data_out;
    output dsp_pkg::stream_ctrl_t ctrl_out;

    dsp_pkg::stream_ctrl_t mul_ctrl;

    // last and user follow stream 1, a beat needs both operands
    always_comb begin
        mul_ctrl       = ctrl_in_1;
        mul_ctrl.valid = ctrl_in_1.valid && valid_in_2;
    end

    fixed_point_multiplier multiplier (
        .aclk   (aclk     ),
        .aclken (aclken   ),
        .a      (data_in_1),
        .b      (data_in_2),
        .p      (data_out )
    );

    n_delay_stream #(
        .N (dsp_pkg::MULTIPLIER_DELAY)     // keep control aligned with the core
    )
    delay_others
    (
        .aclk     (aclk    ),
        .aclken   (aclken  ),
        .arst_n   (arst_n  ),
        .ctrl_in  (mul_ctrl),
        .ctrl_out (ctrl_out)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass message

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dot_product_unit -f vlog.f &&
./obj_dir/Vtb_dot_product_unit | tee /dev/stderr | grep "All tests passed!" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tests/tb_dot_product_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dot_product_unit;

    localparam int LATENCY = 5;                // enabled cycles from a beat to its sum

    typedef struct packed {
        dsp_pkg::word_t        sum;
        dsp_pkg::stream_ctrl_t ctrl;
        int                    due;            // enabled-cycle count at arrival
    } expect_t;

    logic                  aclk;
    logic                  aclken;
    logic                  arst_n;
    dsp_pkg::word_t        a_data;
    dsp_pkg::stream_ctrl_t a_ctrl;
    dsp_pkg::word_t        b_data;
    logic                  b_valid;
    dsp_pkg::word_t        y_data;
    dsp_pkg::stream_ctrl_t y_ctrl;

    expect_t               exp_q[$];
    dsp_pkg::word_t        model_sum;
    logic                  model_restart;
    int                    en_count = 0;
    logic                  edge_en = 1'b0;
    dsp_pkg::word_t        prev_data;
    dsp_pkg::stream_ctrl_t prev_ctrl;
    int                    mismatches;
    int                    failures;
    int                    seed;

    dot_product_unit u_dut (
        .aclk    (aclk   ),
        .aclken  (aclken ),
        .arst_n  (arst_n ),
        .a_data  (a_data ),
        .a_ctrl  (a_ctrl ),
        .b_data  (b_data ),
        .b_valid (b_valid),
        .y_data  (y_data ),
        .y_ctrl  (y_ctrl )
    );

    always #50 aclk = ~aclk;

    // edges on which the pipeline moves
    always @(posedge aclk) begin
        edge_en <= aclken && arst_n;
        if (aclken && arst_n) begin
            en_count <= en_count + 1;
        end
    end

    task automatic check_value(input string name,
                               input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        assert (expected === actual) else begin
            mismatches++;
            $display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // output monitor, sampled mid-cycle
    always @(negedge aclk) begin
        expect_t e;
        if (arst_n && edge_en && y_ctrl.valid) begin
            assert (exp_q.size() > 0) else begin
                failures++;
                $display("output beat at %0t ns when none was expected", $time);
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_value("enabled cycle count", e.due, en_count);
                check_value("y_data", e.sum, y_data);
                check_value("y_ctrl.last", e.ctrl.last, y_ctrl.last);
                check_value("y_ctrl.user", e.ctrl.user, y_ctrl.user);
            end
        end else if (arst_n && edge_en && exp_q.size() > 0) begin
            assert (exp_q[0].due > en_count) else begin
                failures++;
                $display("expected output beat missing at %0t ns", $time);
                void'(exp_q.pop_front());
            end
        end else if (arst_n && !edge_en) begin
            check_value("y_data while stalled", prev_data, y_data);
            check_value("y_ctrl while stalled", prev_ctrl, y_ctrl);
        end
        prev_data = y_data;
        prev_ctrl = y_ctrl;
    end

    // Q8.8 product, full signed product shifted right by the fraction bits
    function automatic dsp_pkg::word_t q88_product(input dsp_pkg::word_t a,
                                                   input dsp_pkg::word_t b);
        logic signed [31:0] wa;
        logic signed [31:0] wb;
        logic signed [31:0] full;
        wa   = a;
        wb   = b;
        full = (wa * wb) >>> 8;
        return full[15:0];
    endfunction

    task automatic model_beat(input dsp_pkg::word_t a, input dsp_pkg::word_t b, input logic last,
                              input logic [dsp_pkg::TUSER_WIDTH-1:0] user);
        expect_t        e;
        dsp_pkg::word_t p;
        p         = q88_product(a, b);
        model_sum = model_restart ? p : model_sum + p;   // wraps modulo 2^16
        model_restart = last;
        e.sum        = model_sum;
        e.ctrl.valid = 1'b1;
        e.ctrl.last  = last;
        e.ctrl.user  = user;
        e.due        = en_count + LATENCY;
        exp_q.push_back(e);
    endtask

    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic send(input dsp_pkg::word_t a, input dsp_pkg::word_t b, input logic av,
                        input logic bv, input logic last,
                        input logic [dsp_pkg::TUSER_WIDTH-1:0] user);
        a_data       = a;
        b_data       = b;
        a_ctrl.valid = av;
        a_ctrl.last  = last;
        a_ctrl.user  = user;
        b_valid      = bv;
        if (aclken && av && bv) begin
            model_beat(a, b, last, user);
        end
        next_cycle();
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < 50) begin
            send('0, '0, 1'b0, 1'b0, 1'b0, '0);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            failures++;
            $display("timeout at %0t ns with %0d output beats still missing", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic test_reset();
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            check_value("y_ctrl.valid in reset", 0, y_ctrl.valid);
            check_value("y_ctrl.last in reset", 0, y_ctrl.last);
        end
        arst_n = 1'b1;
        for (int i = 0; i < 6; i++) begin
            send('0, '0, 1'b0, 1'b0, 1'b0, '0);
            check_value("y_ctrl.valid after reset", 0, y_ctrl.valid);
            check_value("y_ctrl.last after reset", 0, y_ctrl.last);
        end
    endtask

    task automatic test_single_vector();
        send(16'h0180, 16'h0200, 1'b1, 1'b1, 1'b0, 8'h11);   // 1.5 * 2.0
        send(16'hfec0, 16'h0080, 1'b1, 1'b1, 1'b0, 8'h11);   // -1.25 * 0.5
        send(16'h0001, 16'h0001, 1'b1, 1'b1, 1'b0, 8'h11);   // truncates to 0
        send(16'hffff, 16'h0001, 1'b1, 1'b1, 1'b1, 8'h11);   // truncates to -1 lsb
        wait_drain();
    endtask

    task automatic test_back_to_back();
        send(16'h0100, 16'h0300, 1'b1, 1'b1, 1'b0, 8'h21);
        send(16'h0200, 16'h0200, 1'b1, 1'b1, 1'b0, 8'h21);
        send(16'hff00, 16'h0100, 1'b1, 1'b1, 1'b1, 8'h21);
        send(16'h0080, 16'h0080, 1'b1, 1'b1, 1'b0, 8'h22);   // restarts, no carry over
        send(16'h0400, 16'hfe00, 1'b1, 1'b1, 1'b0, 8'h22);
        send(16'h0100, 16'h0100, 1'b1, 1'b1, 1'b1, 8'h22);
        wait_drain();
    endtask

    task automatic test_gaps();
        send(16'h0200, 16'h0180, 1'b1, 1'b1, 1'b0, 8'h31);
        send(16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 8'h00);
        send(16'h7000, 16'h7000, 1'b1, 1'b0, 1'b1, 8'h31);   // a only, last must not count
        send(16'h7000, 16'h7000, 1'b0, 1'b1, 1'b0, 8'h31);   // b only
        send(16'hff80, 16'h0200, 1'b1, 1'b1, 1'b0, 8'h31);
        send(16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 8'h00);
        send(16'h0300, 16'h0100, 1'b1, 1'b1, 1'b1, 8'h31);
        wait_drain();
    endtask

    task automatic test_stall();
        send(16'h0100, 16'h0100, 1'b1, 1'b1, 1'b0, 8'h41);
        send(16'h0200, 16'h0100, 1'b1, 1'b1, 1'b0, 8'h41);
        send(16'h0300, 16'h0100, 1'b1, 1'b1, 1'b0, 8'h41);
        aclken = 1'b0;
        for (int i = 0; i < 4; i++) begin
            send(16'h5555, 16'h2222, 1'b1, 1'b1, 1'b1, 8'hee);   // ignored while stalled
        end
        aclken = 1'b1;
        send(16'h0400, 16'h0100, 1'b1, 1'b1, 1'b0, 8'h41);
        send(16'h0500, 16'h0100, 1'b1, 1'b1, 1'b1, 8'h41);
        wait_drain();
    endtask

    task automatic test_random();
        int len;
        int r;
        logic [dsp_pkg::TUSER_WIDTH-1:0] user;
        for (int v = 0; v < 6; v++) begin
            r    = $random(seed);
            len  = 1 + ((r % 6) + 6) % 6;
            user = 8'($random(seed));
            for (int i = 0; i < len; i++) begin
                if (($random(seed) & 3) == 0) begin
                    send('0, '0, 1'b0, 1'b0, 1'b0, '0);          // occasional gap
                end
                send(16'($random(seed)), 16'($random(seed)), 1'b1, 1'b1, i == len - 1, user);
            end
        end
        wait_drain();
    endtask

    initial begin
        aclk          = 1'b0;
        aclken        = 1'b1;
        arst_n        = 1'b0;
        a_data        = '0;
        a_ctrl        = '0;
        b_data        = '0;
        b_valid       = 1'b0;
        model_sum     = '0;
        model_restart = 1'b0;
        mismatches    = 0;
        failures      = 0;
        seed          = 79381;

        test_reset();
        test_single_vector();
        test_back_to_back();
        test_gaps();
        test_stall();
        test_random();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/dot_product_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot_product_unit (
    aclk,
    aclken,
    arst_n,

    a_data,
    a_ctrl,

    b_data,
    b_valid,

    y_data,
    y_ctrl
);

    input  logic                  aclk;
    input  logic                  aclken;
    input  logic                  arst_n;

    input  dsp_pkg::word_t        a_data;
    input  dsp_pkg::stream_ctrl_t a_ctrl;       // last and user come from stream a

    input  dsp_pkg::word_t        b_data;
    input  logic                  b_valid;

    output dsp_pkg::word_t        y_data;       // running sum, full dot product on last
    output dsp_pkg::stream_ctrl_t y_ctrl;

    dsp_pkg::word_t        prod_data;
    dsp_pkg::stream_ctrl_t prod_ctrl;

    // products, 3 enabled cycles
    fixed_point_multiplier_wrapper mul_wrapper (
        .aclk       (aclk     ),
        .aclken     (aclken   ),
        .arst_n     (arst_n   ),

        .data_in_1  (a_data   ),
        .ctrl_in_1  (a_ctrl   ),

        .data_in_2  (b_data   ),
        .valid_in_2 (b_valid  ),

        .data_out   (prod_data),
        .ctrl_out   (prod_ctrl)
    );

    // running sums, 2 more enabled cycles
    fixed_point_accumulator_wrapper acc_wrapper (
        .aclk     (aclk     ),
        .aclken   (aclken   ),
        .arst_n   (arst_n   ),

        .data_in  (prod_data),
        .ctrl_in  (prod_ctrl),

        .data_out (y_data   ),
        .ctrl_out (y_ctrl   )
    );

endmodule

`default_nettype wire

// ==== verilog/n_delay_stream.sv ====
`timescale 1ns/1ps
`default_nettype none

module n_delay_stream #(
    parameter int N = 2
)(
    aclk,
    aclken,
    arst_n,

    ctrl_in,
    ctrl_out
);

    input  logic                  aclk;
    input  logic                  aclken;
    input  logic                  arst_n;

    input  dsp_pkg::stream_ctrl_t ctrl_in;
    output dsp_pkg::stream_ctrl_t ctrl_out;

    dsp_pkg::stream_ctrl_t stage [N];          // stage[0] is the newest entry

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N; i++) begin
                stage[i] <= '0;
            end
        end else if (aclken) begin
            stage[0] <= ctrl_in;
            for (int i = 1; i < N; i++) begin
                stage[i] <= stage[i-1];        // shift one step per enabled cycle
            end
        end
    end

    assign ctrl_out = stage[N-1];

endmodule

`default_nettype wire

// ==== vlog.f ====
common/dsp_pkg.sv
verilog/n_delay_stream.sv
multiplier/fixed_point_multiplier.sv
multiplier/fixed_point_multiplier_wrapper.sv
accumulator/fixed_point_accumulator.sv
accumulator/fixed_point_accumulator_wrapper.sv
verilog/dot_product_unit.sv
tests/tb_dot_product_unit.sv
